//--- verif/bus_input.txt
# columns: mask we0 addr0 wdata0 we1 addr1 wdata1 we2 addr2 wdata2
# all fields hex, mask bit i raises the request of master i
1  0 3 0000  0 0 0000  0 0 0000
7  1 1 a5a5  1 2 1234  1 3 beef
6  0 0 0000  0 1 0000  0 2 0000
1  0 3 0000  0 0 0000  0 0 0000
5  1 4 c001  0 0 0000  1 5 0d15
3  0 5 0000  0 4 0000  0 0 0000
2  0 0 0000  1 6 7777  0 0 0000
4  0 0 0000  0 0 0000  0 6 0000
7  0 1 0000  1 1 2222  0 1 0000
3  1 7 0101  0 7 0000  0 0 0000
6  0 0 0000  1 8 8888  0 8 0000
5  0 9 0000  0 0 0000  0 a 0000
7  1 f ffff  1 e eeee  1 d dddd
7  0 e 0000  0 d 0000  0 f 0000
2  0 0 0000  0 0 0000  0 0 0000
4  0 0 0000  0 0 0000  1 0 4242
1  0 0 0000  0 0 0000  0 0 0000

//--- bus_system.f
src/bus_pkg.sv
src/shared_bus_if.sv
src/bus_arbiter.sv
src/bus_mux.sv
src/bus_memory.sv
src/bus_system.sv
verif/bus_checker.sv
verif/tb_bus_system.sv

//--- verif/tb_bus_system.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bus_system;
    import bus_pkg::*;

    localparam int    CLK_PERIOD   = 100;
    localparam int    RESET_CYCLES = 10;
    localparam int    MAX_ROUNDS   = 64;
    localparam string INPUT_FILE   = "verif/bus_input.txt";

    logic        clk;
    logic        reset;
    arb_vector   m_req;
    arb_vector   m_we;
    addr_t       m_addr  [N_MASTERS];
    data_t       m_wdata [N_MASTERS];
    arb_vector   bus_grant;
    logic        bus_ack;
    data_t       bus_rdata;
    int          checker_errors;

    arb_vector   round_mask  [MAX_ROUNDS];
    arb_vector   round_we    [MAX_ROUNDS];
    addr_t       round_addr  [MAX_ROUNDS][N_MASTERS];
    data_t       round_wdata [MAX_ROUNDS][N_MASTERS];
    int          n_rounds;
    int          current_round;
    int          cycle_limit;
    int          tb_errors;
    int          rounds_passed;
    logic [31:0] lcg_state;

    bus_system i_dut (
        .clk       (clk),
        .reset     (reset),
        .m_req     (m_req),
        .m_we      (m_we),
        .m_addr    (m_addr),
        .m_wdata   (m_wdata),
        .bus_grant (bus_grant),
        .bus_ack   (bus_ack),
        .bus_rdata (bus_rdata)
    );

    bus_checker i_checker (
        .clk         (clk),
        .reset       (reset),
        .m_req       (m_req),
        .m_we        (m_we),
        .m_addr      (m_addr),
        .m_wdata     (m_wdata),
        .bus_grant   (bus_grant),
        .bus_ack     (bus_ack),
        .bus_rdata   (bus_rdata),
        .error_count (checker_errors)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]);
    endfunction

    function automatic int grant_owner(input arb_vector grant);
        for (int i = 0; i < N_MASTERS; i++) begin
            if (grant[i]) return i;
        end
        return -1;
    endfunction

    task automatic load_stimulus();
        int    fd;
        int    n;
        int    f [10];
        string line;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", INPUT_FILE);
            tb_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
            if (n == 10) begin
                if (n_rounds < MAX_ROUNDS) begin
                    round_mask[n_rounds] = arb_vector'(f[0]);
                    for (int m = 0; m < N_MASTERS; m++) begin
                        round_we[n_rounds][m]    = f[1 + 3 * m][0];
                        round_addr[n_rounds][m]  = addr_t'(f[2 + 3 * m]);
                        round_wdata[n_rounds][m] = data_t'(f[3 + 3 * m]);
                    end
                    n_rounds++;
                end else begin
                    $display("too many rounds in %s, extra lines ignored", INPUT_FILE);
                    tb_errors++;
                end
            end else if (n > 0) begin
                $display("stimulus line without 10 fields: %s", line);
                tb_errors++;
            end
        end
        $fclose(fd);
        if (n_rounds == 0) begin
            $display("no stimulus rounds found in %s", INPUT_FILE);
            tb_errors++;
        end
    endtask

    ////////////////////////////////////////
    // one round of master requests
    ////////////////////////////////////////

    task automatic run_round(input int r);
        int errors_before;
        int idx;
        errors_before = tb_errors + checker_errors;
        for (int m = 0; m < N_MASTERS; m++) begin
            m_addr[m]  = round_addr[r][m];
            m_wdata[m] = round_wdata[r][m];
        end
        m_we  = round_we[r];
        m_req = round_mask[r];  // all masked masters at once
        while (m_req != NO_GRANT) begin
            @(negedge clk);
            if (bus_ack) begin
                idx = grant_owner(bus_grant);
                if (idx < 0) begin
                    $display("round %0d: acknowledge seen with no grant", r);
                    tb_errors++;
                end else if (!m_req[idx]) begin
                    $display("round %0d: acknowledge for idle master %0d", r, idx);
                    tb_errors++;
                end else begin
                    m_req[idx] = 1'b0;  // own ack seen, release
                end
            end
        end
        @(negedge clk);  // checker sees the last ack cycle
        if (tb_errors + checker_errors == errors_before) begin
            rounds_passed++;
            $display("round %0d mask %b: ok", r, round_mask[r]);
        end else begin
            $display("round %0d mask %b: %0d errors", r, round_mask[r],
                     tb_errors + checker_errors - errors_before);
        end
    endtask

    initial begin : main
        int total;
        clk           = 1'b0;
        reset         = 1'b1;
        m_req         = NO_GRANT;
        m_we          = '0;
        for (int m = 0; m < N_MASTERS; m++) begin
            m_addr[m]  = '0;
            m_wdata[m] = '0;
        end
        tb_errors     = 0;
        rounds_passed = 0;
        n_rounds      = 0;
        current_round = 0;
        cycle_limit   = 0;
        lcg_state     = 32'd83;
        load_stimulus();
        if (n_rounds > 0) begin
            cycle_limit = n_rounds * N_MASTERS * (MEM_WAIT_CYCLES + 6) + RESET_CYCLES;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        for (int r = 0; r < n_rounds; r++) begin
            current_round = r;
            run_round(r);
            repeat (next_random() % 4) @(negedge clk);  // idle gap
        end
        repeat (2) @(negedge clk);
        total = tb_errors + checker_errors;
        $display("summary: %0d of %0d rounds passed, %0d errors", rounds_passed, n_rounds, total);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin : watchdog
        wait (cycle_limit > 0);
        repeat (cycle_limit) @(posedge clk);
        $display("timeout: round %0d never completed within %0d cycles",
                 current_round, cycle_limit);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/bus_checker.sv
`timescale 1ns/1ps
`default_nettype none

module bus_checker (
    input  logic               clk,
    input  logic               reset,
    input  bus_pkg::arb_vector m_req,
    input  bus_pkg::arb_vector m_we,
    input  bus_pkg::addr_t     m_addr  [bus_pkg::N_MASTERS],
    input  bus_pkg::data_t     m_wdata [bus_pkg::N_MASTERS],
    input  bus_pkg::arb_vector bus_grant,
    input  logic               bus_ack,
    input  bus_pkg::data_t     bus_rdata,
    output int                 error_count
);
    import bus_pkg::*;

    localparam int ACK_LATENCY = MEM_WAIT_CYCLES + 2;  // grant edge to ack edge

    data_t     shadow [MEM_WORDS];  // expected slave contents
    arb_vector prev_grant;
    arb_vector prev_req;
    logic      prev_ack;
    logic      req_seen;
    logic      in_flight;
    int        edge_cnt;
    logic      cmd_we;
    addr_t     cmd_addr;
    data_t     cmd_wdata;

    initial error_count = 0;

    // two's complement trick, keeps only the lowest set bit
    function automatic arb_vector lowest_request(input arb_vector req);
        arb_vector neg;
        neg = ~req + 1'b1;
        return req & neg;
    endfunction

    function automatic int granted_master(input arb_vector grant);
        int idx;
        idx = -1;
        for (int i = N_MASTERS - 1; i >= 0; i--) begin
            if (grant[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        error_count++;
        $display("** Error: %s expected 0x%0h, got 0x%0h at %0t ns",
                 name, expected, actual, $time);
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("%0t ns: %s", $time, what);
    endtask

    task automatic finish_access();
        if (cmd_we) begin
            shadow[cmd_addr] = cmd_wdata;
        end else if (bus_rdata !== shadow[cmd_addr]) begin
            report_value("bus_rdata", shadow[cmd_addr], bus_rdata);
        end
    endtask

    ////////////////////////////////////////
    // per-edge protocol checks
    ////////////////////////////////////////

    always @(posedge clk or posedge reset) begin : watch
        arb_vector expected;
        int        idx;
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                shadow[i] = '0;
            end
            prev_grant = NO_GRANT;
            prev_req   = NO_GRANT;
            prev_ack   = 1'b0;
            req_seen   = 1'b0;
            in_flight  = 1'b0;
            edge_cnt   = 0;
        end else begin
            if (!req_seen) begin  // quiet bus after reset
                if (bus_grant !== NO_GRANT) report_value("bus_grant", NO_GRANT, bus_grant);
                if (bus_ack !== 1'b0) report_value("bus_ack", 1'b0, bus_ack);
            end
            if ($countones(bus_grant) > 1) begin
                report_failure($sformatf("bus_grant 0x%0h has more than one bit set", bus_grant));
            end
            if (prev_grant != NO_GRANT && !prev_ack) begin
                if (bus_grant !== prev_grant) report_value("bus_grant", prev_grant, bus_grant);
            end else begin
                expected = lowest_request(prev_req);
                if (bus_grant !== expected) report_value("bus_grant", expected, bus_grant);
            end

            if (in_flight) edge_cnt++;
            if (bus_ack) begin
                if (!in_flight) begin
                    report_failure("bus_ack pulsed with no transfer in progress");
                end else begin
                    if (edge_cnt != ACK_LATENCY) begin
                        report_failure($sformatf("bus_ack came %0d edges after the grant, not %0d",
                                                 edge_cnt, ACK_LATENCY));
                    end
                    finish_access();
                end
                in_flight = 1'b0;
            end else if (in_flight && edge_cnt >= ACK_LATENCY) begin
                report_failure("bus_ack did not arrive in time for the granted transfer");
                in_flight = 1'b0;
            end

            // a grant loaded at the previous edge starts a transfer
            if (bus_grant != NO_GRANT && (prev_grant == NO_GRANT || prev_ack)) begin
                idx       = granted_master(bus_grant);
                cmd_we    = m_we[idx];
                cmd_addr  = m_addr[idx];
                cmd_wdata = m_wdata[idx];
                in_flight = 1'b1;
                edge_cnt  = 0;
            end

            if (m_req != NO_GRANT) req_seen = 1'b1;
            prev_grant = bus_grant;
            prev_req   = m_req;
            prev_ack   = bus_ack;
        end
    end

endmodule

`default_nettype wire

//--- src/bus_system.sv
`timescale 1ns/1ps
`default_nettype none

module bus_system (
    input  logic               clk,
    input  logic               reset,

    // per-master command inputs
    input  bus_pkg::arb_vector m_req,
    input  bus_pkg::arb_vector m_we,
    input  bus_pkg::addr_t     m_addr  [bus_pkg::N_MASTERS],
    input  bus_pkg::data_t     m_wdata [bus_pkg::N_MASTERS],

    // shared bus status
    output bus_pkg::arb_vector bus_grant,
    output logic               bus_ack,
    output bus_pkg::data_t     bus_rdata
);

    shared_bus_if bus_if ();

    ////////////////////////////////////////
    // arbitration
    ////////////////////////////////////////

    bus_arbiter i_arbiter (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (m_req),
        .bus_ack   (bus_ack),
        .bus_grant (bus_grant)
    );

    ////////////////////////////////////////
    // command routing
    ////////////////////////////////////////

    bus_mux i_mux (
        .bus_grant (bus_grant),
        .m_we      (m_we),
        .m_addr    (m_addr),
        .m_wdata   (m_wdata),
        .bus       (bus_if.mux)
    );

    ////////////////////////////////////////
    // slave
    ////////////////////////////////////////

    bus_memory i_memory (
        .clk   (clk),
        .reset (reset),
        .bus   (bus_if.mem)
    );

    assign bus_ack   = bus_if.ack;    // also closes the arbiter loop
    assign bus_rdata = bus_if.rdata;

endmodule

`default_nettype wire

//--- src/bus_memory.sv
`timescale 1ns/1ps
`default_nettype none

module bus_memory (
    input  logic      clk,
    input  logic      reset,
    shared_bus_if.mem bus
);
    import bus_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        ACK
    } mem_state_t;

    typedef logic [$clog2(MEM_WAIT_CYCLES+1)-1:0] wait_cnt_t;

    mem_state_t state;
    wait_cnt_t  wait_cnt;
    logic       access_done;
    logic       ack_q;

    logic       we_q;
    addr_t      addr_q;
    data_t      wdata_q;
    data_t      rdata_q;
    data_t      mem [MEM_WORDS];

    // last wait edge reached, access happens on this edge
    assign access_done = (state == WAIT) && (wait_cnt == wait_cnt_t'(MEM_WAIT_CYCLES));

    ////////////////////////////////////////
    // access FSM
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= IDLE;
            wait_cnt <= '0;
            ack_q    <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (bus.sel) begin
                        state    <= WAIT;
                        wait_cnt <= '0;
                    end
                end
                WAIT: begin
                    if (access_done) begin
                        state <= ACK;
                        ack_q <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                ACK: begin
                    ack_q <= 1'b0;  // single-cycle pulse
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                    ack_q <= 1'b0;
                end
            endcase
        end
    end

    // command capture at start of access
    always_ff @(posedge clk) begin
        if (state == IDLE && bus.sel) begin
            we_q    <= bus.we;
            addr_q  <= bus.addr;
            wdata_q <= bus.wdata;
        end
    end

    ////////////////////////////////////////
    // register file
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
            rdata_q <= '0;
        end else if (access_done) begin
            if (we_q) begin
                mem[addr_q] <= wdata_q;
            end else begin
                rdata_q <= mem[addr_q];
            end
        end
    end

    assign bus.rdata = rdata_q;
    assign bus.ack   = ack_q;

endmodule

`default_nettype wire

//--- src/bus_mux.sv
`timescale 1ns/1ps
`default_nettype none

module bus_mux (
    input  bus_pkg::arb_vector bus_grant,
    input  bus_pkg::arb_vector m_we,
    input  bus_pkg::addr_t     m_addr  [bus_pkg::N_MASTERS],
    input  bus_pkg::data_t     m_wdata [bus_pkg::N_MASTERS],
    shared_bus_if.mux          bus
);
    import bus_pkg::*;

    logic  we_mux;
    addr_t addr_mux;
    data_t wdata_mux;

    ////////////////////////////////////////
    // and-or select on the one-hot grant
    ////////////////////////////////////////

    always_comb begin
        we_mux    = 1'b0;
        addr_mux  = '0;
        wdata_mux = '0;
        for (int i = 0; i < N_MASTERS; i++) begin
            we_mux    = we_mux | (bus_grant[i] & m_we[i]);
            addr_mux  = addr_mux | ({ADDR_W{bus_grant[i]}} & m_addr[i]);
            wdata_mux = wdata_mux | ({DATA_W{bus_grant[i]}} & m_wdata[i]);
        end
    end

    assign bus.sel   = |bus_grant;  // any master granted
    assign bus.we    = we_mux;
    assign bus.addr  = addr_mux;
    assign bus.wdata = wdata_mux;

endmodule

`default_nettype wire

//--- src/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  logic               clk,
    input  logic               reset,
    input  bus_pkg::arb_vector bus_req,
    input  logic               bus_ack,
    output bus_pkg::arb_vector bus_grant
);
    import bus_pkg::*;

    typedef enum logic {
        READY,
        BUSY
    } arb_state_t;

    arb_state_t state;
    arb_vector  prio_grant;

    ////////////////////////////////////////
    // priority encoder
    ////////////////////////////////////////

    always_comb begin : prio_enc
        logic found;
        prio_grant = NO_GRANT;
        found      = 1'b0;
        for (int i = 0; i < N_MASTERS; i++) begin
            if (!found && bus_req[i]) begin  // lowest index wins
                prio_grant[i] = 1'b1;
                found         = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // grant FSM
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= READY;
            bus_grant <= NO_GRANT;
        end else begin
            case (state)
                READY: begin
                    bus_grant <= prio_grant;  // all zero when idle
                    if (bus_req != NO_GRANT) begin
                        state <= BUSY;
                    end
                end
                BUSY: begin
                    // grant is frozen until the slave completes
                    if (bus_ack) begin
                        bus_grant <= prio_grant;
                        if (bus_req == NO_GRANT) begin
                            state <= READY;
                        end
                    end
                end
                default: begin
                    state     <= READY;
                    bus_grant <= NO_GRANT;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/shared_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface shared_bus_if;
    import bus_pkg::*;

    logic  sel;    // a master holds the bus
    logic  we;
    addr_t addr;
    data_t wdata;
    data_t rdata;  // valid in the ack cycle
    logic  ack;    // one-cycle pulse

    // master side, fed by the multiplexer
    modport mux (
        output sel,
        output we,
        output addr,
        output wdata,
        input  rdata,
        input  ack
    );

    modport mem (
        input  sel,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output ack
    );

endinterface

`default_nettype wire

//--- src/bus_pkg.sv
`default_nettype none

package bus_pkg;

    ////////////////////////////////////////
    // bus dimensions
    ////////////////////////////////////////

    localparam int N_MASTERS       = 3;
    localparam int ADDR_W          = 4;  // 16 words
    localparam int DATA_W          = 16;
    localparam int MEM_WORDS       = 16;
    localparam int MEM_WAIT_CYCLES = 2;  // wait states before ack

    ////////////////////////////////////////
    // vector types
    ////////////////////////////////////////

    typedef logic [N_MASTERS-1:0] arb_vector;  // one bit per master
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [DATA_W-1:0]    data_t;

    localparam arb_vector NO_GRANT = '0;

endpackage

`default_nettype wire
